// ==== include/imuldiv_config.svh ====
/*
  iterative divider configuration
  operand width, iteration counter width and loop length
*/

`ifndef IMULDIV_CONFIG_SVH
`define IMULDIV_CONFIG_SVH

// width of each operand and of each result half
`define IMULDIV_DATA_W 32

// counter must hold IMULDIV_ITERS - 1
`define IMULDIV_CNT_W 5

// one quotient bit per loop cycle
`define IMULDIV_ITERS 32

`endif

// ==== rtl/imuldiv_pkg.sv ====
/*
  shared types for the iterative divider
  function opcode and control FSM states
*/

`default_nettype none

package imuldiv_pkg;

  // --------------------------------------------------
  // request function
  // --------------------------------------------------

  // one bit in the request message
  typedef enum logic {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGNED   = 1'b1
  } div_fn_e;

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------

  // idle waits for a request, calc runs the loop, done holds the response
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } div_state_e;

endpackage

`default_nettype wire

// ==== rtl/div_ctrl_if.sv ====
/*
  divider control to datapath bundle
  enables and mux selects one way, loop status back
*/

`timescale 1ns/1ps
`default_nettype none

interface div_ctrl_if;

  // load working register (remainder and quotient)
  logic a_en;
  // load divisor register
  logic b_en;
  // 0 takes the initial operands, 1 takes the step result
  logic a_mux_sel;
  // 0 reloads the counter, 1 counts down
  logic cntr_mux_sel;
  // latch function bit and operand signs
  logic sign_en;

  // last loop cycle
  logic counter_is_zero;

  // --------------------------------------------------
  // views
  // --------------------------------------------------

  modport ctrl (
    output a_en,
    output b_en,
    output a_mux_sel,
    output cntr_mux_sel,
    output sign_en,
    input  counter_is_zero
  );

  modport dpath (
    input  a_en,
    input  b_en,
    input  a_mux_sel,
    input  cntr_mux_sel,
    input  sign_en,
    output counter_is_zero
  );

endinterface

`default_nettype wire

// ==== rtl/int_div_dpath.sv ====
/*
  divider datapath
  restoring shift-subtract on magnitudes, loop counter and sign fixup
*/

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_config.svh"

module int_div_dpath (
  input  logic                           clk,
  input  logic                           reset,
  input  imuldiv_pkg::div_fn_e           divreq_msg_fn,
  input  logic [`IMULDIV_DATA_W-1:0]     divreq_msg_a,
  input  logic [`IMULDIV_DATA_W-1:0]     divreq_msg_b,
  output logic [2*`IMULDIV_DATA_W-1:0]   divresp_msg_result,
  div_ctrl_if.dpath                      cif
);

  localparam int data_w = `IMULDIV_DATA_W;
  localparam logic [`IMULDIV_CNT_W-1:0] cnt_reload = `IMULDIV_CNT_W'(`IMULDIV_ITERS - 1);

  // --------------------------------------------------
  // operand conditioning
  // --------------------------------------------------

  logic              req_signed;
  logic [data_w-1:0] a_mag;
  logic [data_w-1:0] b_mag;

  assign req_signed = (divreq_msg_fn == imuldiv_pkg::DIV_SIGNED);

  // absolute values only in signed mode
  // most negative value maps onto itself, read as unsigned it is correct
  assign a_mag = (req_signed && divreq_msg_a[data_w-1]) ? (~divreq_msg_a + 1'b1) : divreq_msg_a;
  assign b_mag = (req_signed && divreq_msg_b[data_w-1]) ? (~divreq_msg_b + 1'b1) : divreq_msg_b;

  // --------------------------------------------------
  // restoring step
  // --------------------------------------------------

  // working register holds partial remainder in [2w-1:w] and quotient bits in [w-1:0]
  logic [2*data_w:0] a_reg;
  // divisor sits in the upper half so the subtract lines up with the remainder
  logic [2*data_w:0] b_reg;

  logic [2*data_w:0] a_shift;
  logic [2*data_w:0] sub_out;
  logic [2*data_w:0] step_out;
  logic [2*data_w:0] a_next;

  assign a_shift = a_reg << 1;
  assign sub_out = a_shift - b_reg;

  // top bit set means the divisor did not fit
  // restore the shifted value and shift in a 0, else keep the difference and shift in a 1
  assign step_out = sub_out[2*data_w] ? {a_shift[2*data_w:1], 1'b0}
                                      : {sub_out[2*data_w:1], 1'b1};

  assign a_next = cif.a_mux_sel ? step_out : {{(data_w+1){1'b0}}, a_mag};

  always_ff @(posedge clk) begin
    if (cif.a_en) begin
      a_reg <= a_next;
    end
    if (cif.b_en) begin
      b_reg <= {1'b0, b_mag, {data_w{1'b0}}};
    end
  end

  // --------------------------------------------------
  // iteration counter
  // --------------------------------------------------

  logic [`IMULDIV_CNT_W-1:0] counter_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg <= cnt_reload;
    end else if (cif.cntr_mux_sel) begin
      counter_reg <= counter_reg - 1'b1;
    end else begin
      counter_reg <= cnt_reload;
    end
  end

  assign cif.counter_is_zero = (counter_reg == '0);

  // --------------------------------------------------
  // sign capture
  // --------------------------------------------------

  imuldiv_pkg::div_fn_e fn_reg;
  logic                 a_sign_reg;
  logic                 q_neg_reg;
  logic                 b_zero_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg     <= imuldiv_pkg::DIV_UNSIGNED;
      a_sign_reg <= 1'b0;
      q_neg_reg  <= 1'b0;
      b_zero_reg <= 1'b0;
    end else if (cif.sign_en) begin
      fn_reg     <= divreq_msg_fn;
      a_sign_reg <= divreq_msg_a[data_w-1];
      // raw sign mismatch, qualified by the function at the output
      q_neg_reg  <= divreq_msg_a[data_w-1] ^ divreq_msg_b[data_w-1];
      b_zero_reg <= (divreq_msg_b == '0);
    end
  end

  // --------------------------------------------------
  // result fixup
  // --------------------------------------------------

  logic              div_signed;
  logic              quot_neg;
  logic              rem_neg;
  logic [data_w-1:0] quot_mag;
  logic [data_w-1:0] rem_mag;
  logic [data_w-1:0] quot_out;
  logic [data_w-1:0] rem_out;

  assign div_signed = (fn_reg == imuldiv_pkg::DIV_SIGNED);
  assign quot_neg   = div_signed && q_neg_reg;
  // remainder follows the dividend
  assign rem_neg    = div_signed && a_sign_reg;

  assign quot_mag = a_reg[data_w-1:0];
  assign rem_mag  = a_reg[2*data_w-1:data_w];

  // divide by zero forces all ones
  // the loop already leaves the dividend magnitude as remainder
  assign quot_out = b_zero_reg ? {data_w{1'b1}}
                  : (quot_neg ? (~quot_mag + 1'b1) : quot_mag);
  assign rem_out  = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

  assign divresp_msg_result = {rem_out, quot_out};

  // divisor only ever loads together with the working register
  b_en_with_a_en: assert property (@(posedge clk) disable iff (reset)
    cif.b_en |-> cif.a_en);

endmodule

`default_nettype wire

// ==== rtl/int_div_ctrl.sv ====
/*
  divider control FSM
  val/rdy handshake and datapath enables, idle then calc then done
*/

`timescale 1ns/1ps
`default_nettype none

module int_div_ctrl (
  input  logic      clk,
  input  logic      reset,
  input  logic      divreq_val,
  output logic      divreq_rdy,
  output logic      divresp_val,
  input  logic      divresp_rdy,
  div_ctrl_if.ctrl  cif
);

  imuldiv_pkg::div_state_e state;
  imuldiv_pkg::div_state_e state_next;

  logic req_go;
  logic resp_go;

  // handshake transfers
  assign req_go  = divreq_val && divreq_rdy;
  assign resp_go = divresp_val && divresp_rdy;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::IDLE: begin
        if (req_go) begin
          state_next = imuldiv_pkg::CALC;
        end
      end
      imuldiv_pkg::CALC: begin
        // datapath counter marks the last step
        if (cif.counter_is_zero) begin
          state_next = imuldiv_pkg::DONE;
        end
      end
      imuldiv_pkg::DONE: begin
        if (resp_go) begin
          state_next = imuldiv_pkg::IDLE;
        end
      end
      default: begin
        state_next = imuldiv_pkg::IDLE;
      end
    endcase
  end

  // --------------------------------------------------
  // outputs per state
  // --------------------------------------------------

  always_comb begin
    divreq_rdy       = 1'b0;
    divresp_val      = 1'b0;
    cif.a_en         = 1'b0;
    cif.b_en         = 1'b0;
    cif.a_mux_sel    = 1'b0;
    cif.cntr_mux_sel = 1'b0;
    cif.sign_en      = 1'b0;
    case (state)
      imuldiv_pkg::IDLE: begin
        divreq_rdy  = 1'b1;
        // load operands and signs on the accepting edge
        cif.a_en    = req_go;
        cif.b_en    = req_go;
        cif.sign_en = req_go;
      end
      imuldiv_pkg::CALC: begin
        // one step per cycle
        cif.a_en         = 1'b1;
        cif.a_mux_sel    = 1'b1;
        cif.cntr_mux_sel = 1'b1;
      end
      imuldiv_pkg::DONE: begin
        divresp_val = 1'b1;
      end
      default: begin
        divreq_rdy = 1'b0;
      end
    endcase
  end

  // response waits under back-pressure
  resp_held: assert property (@(posedge clk) disable iff (reset)
    (divresp_val && !divresp_rdy) |=> divresp_val);

  // only one division in flight
  one_in_flight: assert property (@(posedge clk) disable iff (reset)
    !(divreq_rdy && divresp_val));

  // from the accepting edge until the counter runs out every cycle is a loop step
  calc_steps: assert property (@(posedge clk) disable iff (reset)
    (req_go || (state == imuldiv_pkg::CALC && !cif.counter_is_zero)) |=> cif.a_en);

endmodule

`default_nettype wire

// ==== rtl/int_div_iterative.sv ====
/*
  iterative 32-bit integer divider
  control and datapath joined through the control bundle
*/

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_config.svh"

module int_div_iterative (
  input  logic                           clk,
  input  logic                           reset,
  input  imuldiv_pkg::div_fn_e           divreq_msg_fn,
  input  logic [`IMULDIV_DATA_W-1:0]     divreq_msg_a,
  input  logic [`IMULDIV_DATA_W-1:0]     divreq_msg_b,
  input  logic                           divreq_val,
  output logic                           divreq_rdy,
  output logic [2*`IMULDIV_DATA_W-1:0]   divresp_msg_result,
  output logic                           divresp_val,
  input  logic                           divresp_rdy
);

  // --------------------------------------------------
  // control to datapath bundle
  // --------------------------------------------------

  div_ctrl_if cif ();

  // handshake side
  int_div_ctrl ctrl (
    .clk         (clk),
    .reset       (reset),
    .divreq_val  (divreq_val),
    .divreq_rdy  (divreq_rdy),
    .divresp_val (divresp_val),
    .divresp_rdy (divresp_rdy),
    .cif         (cif.ctrl)
  );

  // message side
  int_div_dpath dpath (
    .clk                (clk),
    .reset              (reset),
    .divreq_msg_fn      (divreq_msg_fn),
    .divreq_msg_a       (divreq_msg_a),
    .divreq_msg_b       (divreq_msg_b),
    .divresp_msg_result (divresp_msg_result),
    .cif                (cif.dpath)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
/*
  testbench clock source, free running from time zero
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int period = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  // toggle every half period
  always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== tests/int_div_tb.sv ====
/*
  testbench for the iterative divider
  random and corner requests, reference check, latency and back-pressure
*/

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_config.svh"

module int_div_tb;

  localparam int data_w    = `IMULDIV_DATA_W;
  localparam int max_stall = 8;
  // requests over all six tests
  localparam int n_req     = 73;

  logic                 clk;
  logic                 reset;
  imuldiv_pkg::div_fn_e divreq_msg_fn;
  logic [data_w-1:0]    divreq_msg_a;
  logic [data_w-1:0]    divreq_msg_b;
  logic                 divreq_val;
  logic                 divreq_rdy;
  logic [2*data_w-1:0]  divresp_msg_result;
  logic                 divresp_val;
  logic                 divresp_rdy;

  integer              seed;
  int                  error_count;
  int                  req_count;
  int                  resp_count;
  int                  cyc;
  bit                  bp_on;
  bit                  in_flight;
  bit                  resp_seen;
  logic [2*data_w-1:0] held_result;
  logic [2*data_w-1:0] exp_q[$];
  int                  edge_q[$];
  int                  stall_q[$];

  tb_clock_gen clk_gen (.clk(clk));

  int_div_iterative dut (
    .clk                (clk),
    .reset              (reset),
    .divreq_msg_fn      (divreq_msg_fn),
    .divreq_msg_a       (divreq_msg_a),
    .divreq_msg_b       (divreq_msg_b),
    .divreq_val         (divreq_val),
    .divreq_rdy         (divreq_rdy),
    .divresp_msg_result (divresp_msg_result),
    .divresp_val        (divresp_val),
    .divresp_rdy        (divresp_rdy)
  );

  // --------------------------------------------------
  // reference model and helpers
  // --------------------------------------------------

  // remainder in the upper half, quotient in the lower half
  function automatic logic [2*data_w-1:0] ref_div(input imuldiv_pkg::div_fn_e fn,
                                                  input logic [data_w-1:0] a,
                                                  input logic [data_w-1:0] b);
    logic signed [data_w-1:0] sa;
    logic signed [data_w-1:0] sb;
    logic [data_w-1:0]        q;
    logic [data_w-1:0]        r;
    sa = a;
    sb = b;
    if (b == '0) begin
      // divide by zero, all ones and the dividend back
      q = '1;
      r = a;
    end else if (fn == imuldiv_pkg::DIV_UNSIGNED) begin
      q = a / b;
      r = a % b;
    end else if (a == {1'b1, {(data_w-1){1'b0}}} && sb == -1) begin
      // most negative over minus one wraps to itself
      q = a;
      r = '0;
    end else begin
      // truncates toward zero, remainder keeps the dividend sign
      q = sa / sb;
      r = sa % sb;
    end
    return {r, q};
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    error_count++;
  endtask

  // present one request on a falling edge, return at its transfer edge
  task automatic send(input imuldiv_pkg::div_fn_e fn, input logic [data_w-1:0] a,
                      input logic [data_w-1:0] b);
    @(negedge clk);
    divreq_msg_fn = fn;
    divreq_msg_a  = a;
    divreq_msg_b  = b;
    divreq_val    = 1'b1;
    // rdy only moves on rising edges
    while (!divreq_rdy) @(negedge clk);
    @(posedge clk);
  endtask

  // drop val, wait until every response is back, print the test line
  task automatic finish_test(input string name, input int err0, input int resp0);
    @(negedge clk);
    divreq_val = 1'b0;
    while (resp_count != req_count) @(negedge clk);
    $display("test %s: %0d responses, %0d errors", name, resp_count - resp0,
             error_count - err0);
  endtask

  // --------------------------------------------------
  // comparing process, samples on the rising edge
  // --------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      cyc = cyc + 1;
      if (in_flight && divreq_rdy) begin
        report_error("divreq_rdy high while a division is in flight");
      end
      if (divresp_val && edge_q.size() == 0) begin
        $display("a response came out with no request outstanding");
        error_count++;
      end else if (divresp_val) begin
        if (!resp_seen) begin
          resp_seen   = 1'b1;
          held_result = divresp_msg_result;
          if (cyc - edge_q[0] != `IMULDIV_ITERS + 1) begin
            report_error($sformatf("response after %0d edges, expected %0d",
                                   cyc - edge_q[0], `IMULDIV_ITERS + 1));
          end
        end else if (divresp_msg_result != held_result) begin
          report_error("result changed while divresp_rdy was low");
        end
        // response transfer
        if (divresp_rdy) begin
          if (divresp_msg_result != exp_q[0]) begin
            report_error($sformatf("result %h, expected %h", divresp_msg_result, exp_q[0]));
          end
          void'(exp_q.pop_front());
          void'(edge_q.pop_front());
          resp_count++;
          in_flight = 1'b0;
          resp_seen = 1'b0;
        end
      end
      // request transfer, expected value queued here
      if (divreq_val && divreq_rdy) begin
        exp_q.push_back(ref_div(divreq_msg_fn, divreq_msg_a, divreq_msg_b));
        edge_q.push_back(cyc);
        in_flight = 1'b1;
        req_count++;
      end
    end
  end

  // response side, optional stall before rdy
  initial begin
    int stall;
    forever begin
      @(negedge clk);
      if (divresp_val && !reset) begin
        stall = (bp_on && stall_q.size() > 0) ? stall_q.pop_front() : 0;
        divresp_rdy = 1'b0;
        repeat (stall) @(negedge clk);
        divresp_rdy = 1'b1;
        // transfer happens on the edge in between
        @(negedge clk);
        divresp_rdy = 1'b0;
      end
    end
  end

  // watchdog sized from the worst case per request
  initial begin
    #((10 + n_req * (`IMULDIV_ITERS + 1 + max_stall + 4)) * 20);
    $display("timeout: the divider stopped answering after %0d of %0d requests",
             resp_count, n_req);
    $display("Regression failed");
    $finish;
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin
    int                err0;
    int                resp0;
    int                k;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    seed          = 67;
    error_count   = 0;
    req_count     = 0;
    resp_count    = 0;
    cyc           = 0;
    bp_on         = 1'b0;
    in_flight     = 1'b0;
    resp_seen     = 1'b0;
    reset         = 1'b1;
    divreq_msg_fn = imuldiv_pkg::DIV_UNSIGNED;
    divreq_msg_a  = '0;
    divreq_msg_b  = '0;
    divreq_val    = 1'b0;
    divresp_rdy   = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // unsigned, odd requests get a small dividend so the divisor is larger
    err0  = error_count;
    resp0 = resp_count;
    for (k = 0; k < 20; k++) begin
      a = $random(seed);
      b = $random(seed);
      if (k % 2 == 1) begin
        a = a >> 12;
      end else begin
        b = b >> (k % 31);
      end
      if (b == '0) begin
        b = 1;
      end
      send(imuldiv_pkg::DIV_UNSIGNED, a, b);
    end
    finish_test("unsigned", err0, resp0);

    // signed, bits 1 and 0 of k pick the operand signs
    err0  = error_count;
    resp0 = resp_count;
    for (k = 0; k < 24; k++) begin
      a = $random(seed) & 32'h7fffffff;
      b = ($random(seed) & 32'h7fffffff) >> (k % 29);
      if (b == '0) begin
        b = 1;
      end
      if (k[1]) begin
        a = -a;
      end
      if (k[0]) begin
        b = -b;
      end
      send(imuldiv_pkg::DIV_SIGNED, a, b);
    end
    finish_test("signed", err0, resp0);

    // divisor zero in both modes
    err0  = error_count;
    resp0 = resp_count;
    send(imuldiv_pkg::DIV_UNSIGNED, 32'd12345, '0);
    send(imuldiv_pkg::DIV_SIGNED, 32'hfffffc00, '0);
    send(imuldiv_pkg::DIV_SIGNED, 32'h80000000, '0);
    send(imuldiv_pkg::DIV_UNSIGNED, 32'hffffffff, '0);
    finish_test("divide by zero", err0, resp0);

    // most negative over minus one, plus two neighbours
    err0  = error_count;
    resp0 = resp_count;
    send(imuldiv_pkg::DIV_SIGNED, 32'h80000000, 32'hffffffff);
    send(imuldiv_pkg::DIV_UNSIGNED, 32'h80000000, 32'hffffffff);
    send(imuldiv_pkg::DIV_SIGNED, 32'h80000000, 32'h00000001);
    finish_test("signed overflow", err0, resp0);

    // requests with idle gaps, latency checked by the monitor
    err0  = error_count;
    resp0 = resp_count;
    for (k = 0; k < 6; k++) begin
      a = $random(seed);
      b = $random(seed) >> 16;
      send(imuldiv_pkg::div_fn_e'(a[0]), a, b);
      @(negedge clk);
      divreq_val = 1'b0;
      repeat ($unsigned($random(seed)) % 5) @(negedge clk);
    end
    finish_test("latency", err0, resp0);

    // back-to-back requests with response stalls of 0 to 8 cycles
    err0  = error_count;
    resp0 = resp_count;
    for (k = 0; k < 16; k++) begin
      stall_q.push_back($unsigned($random(seed)) % (max_stall + 1));
    end
    bp_on = 1'b1;
    for (k = 0; k < 16; k++) begin
      a = $random(seed);
      b = $random(seed) >> (k % 32);
      send(imuldiv_pkg::div_fn_e'(b[0]), a, b);
    end
    finish_test("back-pressure", err0, resp0);

    $display("done: %0d requests, %0d responses, %0d errors", req_count, resp_count,
             error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/imuldiv_pkg.sv
rtl/div_ctrl_if.sv
rtl/int_div_dpath.sv
rtl/int_div_ctrl.sv
rtl/int_div_iterative.sv
tests/tb_clock_gen.sv
tests/int_div_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the divider testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module int_div_tb -o int_div_sim

status=0
./obj_dir/int_div_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Regression failed" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
